// File: insn_trace.txt
# R addr data | T test_name | I word rd nimm imm1 imm2 gap exec e_a e_b mem m_a1 wb
# all hex; gap is cycles since the previous issue, nimm words follow the instruction
R 01 11111111
R 02 22222222
R 03 00000003
R 04 44440000
R 1d 1d1d0000
R 1f 00000100
T reg_ops
I 02011140 08b 0 00000000 00000000 2 01a1f 11111111 22222222 11 00000000 04a0
I 1a032180 193 0 00000000 00000000 1 0021f 00000003 44440000 11 00000000 04c0
I 2a6119c0 08f 0 00000000 00000000 1 0047f 11111111 00000003 11 00000000 0000
T immediates
I 1a011230 088 2 cafe0001 0bad0002 2 0021f cafe0001 0bad0002 11 00000000 0500
I 1c020250 101 1 00000010 00000000 2 0041f 22222222 00000010 11 00000000 0520
I 0a030a90 185 0 00000000 00000000 2 0161f 00000003 00000000 11 00000000 0540
T inc_dec_unknown
I 260402c0 201 0 00000000 00000000 1 0021f 44440000 00000001 11 00000000 0560
I 28611300 089 0 00000000 00000000 1 0047f 11111111 00000001 11 00000000 0580
I 50011030 000 0 00000000 00000000 1 00000 00000000 00000000 00 00000000 0000
T mem_io
I 38030340 181 0 00000000 00000000 1 00001 00000000 00000000 21 00000003 05a0
I 380003b0 000 1 00001000 00000000 1 00001 00000000 00000000 21 00001000 05c0
I 3e011000 08b 0 00000000 00000000 2 00001 00000000 22222222 1b 11111111 0000
T branch
I 34030800 1ff 0 00000000 00000000 1 00001 00000003 00000100 11 00000000 23fd
I 36020000 e81 0 00000000 00000000 1 00001 1d1d0000 00000000 11 00000000 07e0
I 32040000 f93 0 00000000 00000000 1 00201 00000100 44440000 11 00000000 07e0

// File: build.f
+incdir+.
isa_pkg.sv
decode_pkg.sv
opcode_table.sv
imm_sequencer.sv
operand_stage.sv
insn_decoder.sv
tb_insn_decoder.sv

// File: Bender.yml
package:
  name: insn_decoder

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - isa_pkg.sv
      - decode_pkg.sv
      - opcode_table.sv
      - imm_sequencer.sv
      - operand_stage.sv
      - insn_decoder.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - tb_insn_decoder.sv

// File: tb_insn_decoder.sv
`timescale 1ns/10ps
`include "insn_macros.svh"

module tb_insn_decoder;

    typedef struct packed {
        decode_pkg::exec_ctl_t exec;
        logic [`WORD_W-1:0]    e_a;
        logic [`WORD_W-1:0]    e_b;
        decode_pkg::mem_ctl_t  mem;
        logic [`WORD_W-1:0]    m_a1;
        decode_pkg::reg_wb_t   wb;
    } issue_t;                          // one issued bundle

    logic                  clk;
    logic                  rst;
    logic [`WORD_W-1:0]    word;
    logic [`WORD_W-1:0]    r1;
    logic [`WORD_W-1:0]    r2;
    decode_pkg::exec_ctl_t exec;
    logic [`WORD_W-1:0]    e_a;
    logic [`WORD_W-1:0]    e_b;
    decode_pkg::mem_ctl_t  mem;
    logic [`WORD_W-1:0]    m_a1;
    decode_pkg::reg_wb_t   wb;
    decode_pkg::reg_rd_t   rd;
    logic                  d_pass;

    logic [`WORD_W-1:0]  regs [0:31];       // register file model
    logic [`WORD_W-1:0]  word_q [$];        // fetch stream
    logic                insn_q [$];        // word is an instruction
    decode_pkg::reg_rd_t rdx_q [$];         // rd expected after it
    int                  wtest_q [$];
    issue_t              exp_q [$];         // expected issues in order
    int                  gap_q [$];         // cycles since previous issue
    int                  etest_q [$];
    logic [8*24-1:0]     test_name [0:15];
    int                  test_err [0:15];
    int                  n_tests;
    int                  n_words;
    int                  errors;
    int                  checks;
    int                  tests_failed;
    logic                loaded;

    // reg file answers the registered read request
    assign r1 = (rd.read[0] === 1'b1) ? regs[rd.r1_addr] : '0;
    assign r2 = (rd.read[1] === 1'b1) ? regs[rd.r2_addr] : '0;

    insn_decoder insn_decoder_inst (
        .clk    (clk),
        .rst    (rst),
        .word   (word),
        .r1     (r1),
        .r2     (r2),
        .exec   (exec),
        .e_a    (e_a),
        .e_b    (e_b),
        .mem    (mem),
        .m_a1   (m_a1),
        .wb     (wb),
        .rd     (rd),
        .d_pass (d_pass)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;          // 4 ns period
    end

    task automatic compare_value(input string name, input logic [`WORD_W-1:0] expected,
                                 input logic [`WORD_W-1:0] actual, input int t);
        checks++;
        if (actual !== expected) begin
            $display("FAILED %s expected 0x%0h actual 0x%0h", name, expected, actual);
            errors++;
            if (t >= 0)
                test_err[t]++;
        end
    endtask

    task automatic report_test(input int t);
        if (test_err[t] == 0) begin
            $display("test %0s: ok", test_name[t]);
        end else begin
            $display("test %0s: %0d errors", test_name[t], test_err[t]);
            tests_failed++;
        end
    endtask

    task automatic load_trace;
        int              fd;
        int              code;
        int              k;
        logic [8*8-1:0]  tag;
        logic [8*24-1:0] name;
        logic [8*128-1:0] line;
        logic [31:0]     w, rdv, nimm, i1, i2, gap;
        logic [31:0]     ex, ea, eb, mm, ma, wbv;
        fd = $fopen("insn_trace.txt", "r");
        if (fd == 0) begin
            $display("cannot open trace file insn_trace.txt");
            errors++;
            return;
        end
        while ($fscanf(fd, "%s", tag) == 1) begin
            if (tag == "#") begin
                code = $fgets(line, fd);            // skip comment
            end else if (tag == "R") begin
                code = $fscanf(fd, "%h %h", k, w);
                regs[k[4:0]] = w;
            end else if (tag == "T" && n_tests < 16) begin
                code = $fscanf(fd, "%s", name);
                test_name[n_tests] = name;
                test_err[n_tests]  = 0;
                n_tests++;
            end else if (tag == "I") begin
                code = $fscanf(fd, "%h %h %h %h %h %h %h %h %h %h %h %h",
                               w, rdv, nimm, i1, i2, gap, ex, ea, eb, mm, ma, wbv);
                if (code != 12) begin
                    $display("short instruction record in trace file");
                    errors++;
                end
                word_q.push_back(w);
                insn_q.push_back(1'b1);
                rdx_q.push_back(decode_pkg::reg_rd_t'(rdv[11:0]));
                wtest_q.push_back(n_tests - 1);
                for (k = 0; k < nimm; k++) begin   // immediates follow the insn
                    word_q.push_back(k == 0 ? i1 : i2);
                    insn_q.push_back(1'b0);
                    rdx_q.push_back('0);
                    wtest_q.push_back(n_tests - 1);
                end
                exp_q.push_back(issue_t'({ex[16:0], ea, eb, mm[7:0], ma, wbv[13:0]}));
                gap_q.push_back(gap);
                etest_q.push_back(n_tests - 1);
            end else begin
                $display("unknown record in trace file");
                errors++;
            end
        end
        $fclose(fd);
        n_words = word_q.size();
        if (exp_q.size() == 0) begin
            $display("trace file holds no expected issue");
            errors++;
        end
    endtask

    // driver, rd checks and final report
    initial begin
        int                  i;
        int                  reset_err;
        int                  rd_test;
        logic                have_rd;
        decode_pkg::reg_rd_t rd_exp;
        rst          = 1'b1;
        word         = '0;
        errors       = 0;
        checks       = 0;
        n_tests      = 0;
        n_words      = 0;
        tests_failed = 0;
        loaded       = 1'b0;
        reset_err    = 0;
        rd_test      = -1;
        have_rd      = 1'b0;
        rd_exp       = '0;
        for (i = 0; i < 32; i++)
            regs[i] = '0;
        load_trace();
        loaded = 1'b1;
        repeat (3) begin                    // idle outputs in reset
            @(posedge clk);
            #1;
            checks++;
            if (d_pass !== 1'b0 || rd !== '0) begin
                $display("d_pass or rd not idle during reset");
                errors++;
                reset_err++;
            end
        end
        if (reset_err == 0) begin
            $display("test reset_idle: ok");
        end else begin
            $display("test reset_idle: %0d errors", reset_err);
            tests_failed++;
        end
        rst = 1'b0;
        while (word_q.size() != 0 || exp_q.size() != 0) begin
            if (word_q.size() != 0) begin
                word    = word_q.pop_front();
                have_rd = insn_q.pop_front();
                rd_exp  = rdx_q.pop_front();
                rd_test = wtest_q.pop_front();
            end else begin
                word    = '0;               // nop filler while draining
                have_rd = 1'b0;
            end
            @(posedge clk);
            #1;
            if (have_rd)
                compare_value("rd", rd_exp, rd, rd_test);
        end
        repeat (2) @(posedge clk);
        #2;
        $display("checks %0d, errors %0d, tests %0d, tests failed %0d",
                 checks, errors, n_tests + 1, tests_failed);
        if (errors == 0)
            $display("TB PASSED");
        else
            $display("TB FAILED");
        $finish;
    end

    // issue checker, one expectation per d_pass pulse
    initial begin
        int     cyc;
        int     prev;
        int     t;
        int     gap;
        issue_t e;
        cyc  = 0;
        prev = 0;
        @(negedge rst);
        forever begin
            @(posedge clk);
            #1;
            cyc++;
            if (d_pass === 1'b1) begin
                if (exp_q.size() == 0) begin
                    e   = '0;               // filler nops issue empty
                    t   = -1;
                end else begin
                    e   = exp_q.pop_front();
                    gap = gap_q.pop_front();
                    t   = etest_q.pop_front();
                end
                if (t >= 0)
                    compare_value("d_pass spacing", gap, cyc - prev, t);
                compare_value("exec", e.exec, exec, t);
                compare_value("e_a", e.e_a, e_a, t);
                compare_value("e_b", e.e_b, e_b, t);
                compare_value("mem", e.mem, mem, t);
                compare_value("m_a1", e.m_a1, m_a1, t);
                compare_value("wb", e.wb, wb, t);
                if (t >= 0 && (etest_q.size() == 0 || etest_q[0] != t))
                    report_test(t);         // last issue of this test
                prev = cyc;
            end
        end
    end

    // watchdog
    initial begin
        wait (loaded);
        #((2 * n_words + 30) * 4);          // two cycles per word plus reset and drain
        $display("timeout: issue missing");
        $display("TB FAILED");
        $finish;
    end

endmodule

// File: insn_decoder.sv
`timescale 1ns/10ps
`include "insn_macros.svh"

module insn_decoder (
    input  logic                  clk,
    input  logic                  rst,
    input  logic [`WORD_W-1:0]    word,
    input  logic [`WORD_W-1:0]    r1,
    input  logic [`WORD_W-1:0]    r2,
    output decode_pkg::exec_ctl_t exec,
    output logic [`WORD_W-1:0]    e_a,
    output logic [`WORD_W-1:0]    e_b,
    output decode_pkg::mem_ctl_t  mem,
    output logic [`WORD_W-1:0]    m_a1,
    output decode_pkg::reg_wb_t   wb,
    output decode_pkg::reg_rd_t   rd,
    output logic                  d_pass
);

    decode_pkg::dec_ctl_t ctl;
    decode_pkg::reg_rd_t  rd_req;
    logic                 decode, imm1, imm2, issue;

    opcode_table opcode_table_inst (
        .word   (word),
        .ctl    (ctl),
        .rd_req (rd_req)
    );

    imm_sequencer imm_sequencer_inst (
        .clk       (clk),
        .rst       (rst),
        .imm_count (ctl.imm_count),
        .decode    (decode),
        .imm1      (imm1),
        .imm2      (imm2),
        .issue     (issue),
        .d_pass    (d_pass)
    );

    operand_stage operand_stage_inst (
        .clk (clk), .rst (rst),
        .decode (decode), .imm1 (imm1), .imm2 (imm2), .issue (issue),
        .word (word), .r1 (r1), .r2 (r2),
        .ctl_in (ctl), .rd_in (rd_req),
        .exec (exec), .e_a (e_a), .e_b (e_b),
        .mem (mem), .m_a1 (m_a1), .wb (wb), .rd (rd)
    );

endmodule

// File: operand_stage.sv
`timescale 1ns/10ps
`include "insn_macros.svh"

module operand_stage (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   decode,
    input  logic                   imm1,
    input  logic                   imm2,
    input  logic                   issue,
    input  logic [`WORD_W-1:0]     word,
    input  logic [`WORD_W-1:0]     r1,
    input  logic [`WORD_W-1:0]     r2,
    input  decode_pkg::dec_ctl_t   ctl_in,
    input  decode_pkg::reg_rd_t    rd_in,
    output decode_pkg::exec_ctl_t  exec,
    output logic [`WORD_W-1:0]     e_a,
    output logic [`WORD_W-1:0]     e_b,
    output decode_pkg::mem_ctl_t   mem,
    output logic [`WORD_W-1:0]     m_a1,
    output decode_pkg::reg_wb_t    wb,
    output decode_pkg::reg_rd_t    rd
);

    decode_pkg::dec_ctl_t ctl_q;      // control of insn in flight
    logic [`WORD_W-1:0]   imm_q;      // first of two immediates
    logic [`WORD_W-1:0]   a_imm;
    logic [`WORD_W-1:0]   val_a;
    logic [`WORD_W-1:0]   val_b;

    assign a_imm = imm2 ? imm_q : word;   // k=2 gives held word to a

    always_comb begin
        case (ctl_q.src_a)
            isa_pkg::SRC_REG: val_a = r1;
            isa_pkg::SRC_IMM: val_a = a_imm;
            isa_pkg::SRC_ONE: val_a = `WORD_W'(1);
            default:          val_a = '0;
        endcase
        case (ctl_q.src_b)
            isa_pkg::SRC_REG: val_b = r2;
            isa_pkg::SRC_IMM: val_b = word;  // last imm word always to b
            isa_pkg::SRC_ONE: val_b = `WORD_W'(1);
            default:          val_b = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (imm1 && ctl_q.imm_count == 2'd2)
            imm_q <= word;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ctl_q <= '0;
            rd    <= '0;
            exec  <= '0;
            mem   <= '0;
            wb    <= '0;
            e_a   <= '0;
            e_b   <= '0;
            m_a1  <= '0;
        end else begin
            if (decode) begin
                ctl_q <= ctl_in;
                rd    <= rd_in;  // reg file answers during next cycle
            end
            if (issue) begin
                exec <= ctl_q.exec;
                mem  <= ctl_q.mem;
                wb   <= ctl_q.wb;
                e_a  <= ctl_q.to_mem ? '0 : val_a;
                m_a1 <= ctl_q.to_mem ? val_a : '0;
                e_b  <= val_b;
            end else begin       // bundle only for one cycle
                exec <= '0;
                mem  <= '0;
                wb   <= '0;
                e_a  <= '0;
                e_b  <= '0;
                m_a1 <= '0;
            end
        end
    end

    // memory ops take at most one immediate, for the address
    a_mem_one_imm: assert property (@(posedge clk) disable iff (rst)
        decode |-> !(ctl_in.to_mem && ctl_in.imm_count == 2'd2));

endmodule

// File: imm_sequencer.sv
`timescale 1ns/10ps

module imm_sequencer (
    input  logic       clk,
    input  logic       rst,
    input  logic [1:0] imm_count,
    output logic       decode,
    output logic       imm1,
    output logic       imm2,
    output logic       issue,
    output logic       d_pass
);

    localparam logic [1:0] S_INSN = 2'd0;
    localparam logic [1:0] S_IMM1 = 2'd1;
    localparam logic [1:0] S_IMM2 = 2'd2;

    logic [1:0] state;
    logic [1:0] cnt_q;    // imm count of insn in flight
    logic       pend;     // k<2 insn issues next edge

    assign decode = (state == S_INSN);
    assign imm1   = (state == S_IMM1);
    assign imm2   = (state == S_IMM2);
    assign issue  = pend | imm2;

    always_ff @(posedge clk) begin
        if (rst) begin
            state  <= S_INSN;
            cnt_q  <= 2'd0;
            pend   <= 1'b0;
            d_pass <= 1'b0;
        end else begin
            d_pass <= issue;
            pend   <= decode && (imm_count < 2'd2);
            case (state)
                S_INSN: begin
                    cnt_q <= imm_count;
                    state <= (imm_count == 2'd0) ? S_INSN : S_IMM1;
                end
                S_IMM1: state <= (cnt_q == 2'd2) ? S_IMM2 : S_INSN;
                default: state <= S_INSN;  // after imm2
            endcase
        end
    end

    // fsm never reaches encoding 3
    a_state_legal: assert property (@(posedge clk) disable iff (rst) state != 2'd3);

endmodule

// File: opcode_table.sv
`timescale 1ns/10ps
`include "insn_macros.svh"

module opcode_table (
    input  logic [`WORD_W-1:0]   word,
    output decode_pkg::dec_ctl_t ctl,
    output decode_pkg::reg_rd_t  rd_req
);

    logic [`OPCODE_W-1:0]   opc;
    logic [`REG_ADDR_W-1:0] fa, fb, fc, fd;
    logic [1:0]             imm_raw;
    logic [1:0]             imm_sel;
    logic [1:0]             rd_mask;
    logic                   one_b;
    logic                   single;   // single operand, kills imm to b
    logic                   no_imm;   // mul, ret, mov

    assign opc     = word[`F_OPCODE];
    assign fa      = word[`F_A];
    assign fb      = word[`F_B];
    assign fc      = word[`F_C];
    assign fd      = word[`F_D];
    assign imm_raw = word[`F_IMM_SEL];

    always_comb begin
        ctl                  = '0;
        rd_req               = '0;
        one_b                = 1'b0;
        single               = 1'b0;
        no_imm               = 1'b0;
        rd_mask              = 2'b11;  // most ops read a and b
        ctl.exec.cond        = word[`F_COND];
        ctl.exec.is_cond     = 1'b1;
        ctl.mem.r1_op        = isa_pkg::MEM_PASS;
        ctl.mem.r2_op        = isa_pkg::MEM_PASS;
        ctl.wb.op            = isa_pkg::WB_ONE;
        ctl.wb.a1            = fc;
        rd_req.r1_addr       = fa;
        rd_req.r2_addr       = fb;
        case (isa_pkg::opcode_e'(opc))
            isa_pkg::OP_OR:   ctl.exec.alu_op = isa_pkg::ALU_OR;
            isa_pkg::OP_NOR:  ctl.exec.alu_op = isa_pkg::ALU_NOR;
            isa_pkg::OP_AND:  ctl.exec.alu_op = isa_pkg::ALU_AND;
            isa_pkg::OP_NAND: ctl.exec.alu_op = isa_pkg::ALU_NAND;
            isa_pkg::OP_XOR:  ctl.exec.alu_op = isa_pkg::ALU_XOR;
            isa_pkg::OP_LSL:  ctl.exec.alu_op = isa_pkg::ALU_SHL;
            isa_pkg::OP_LSR:  ctl.exec.alu_op = isa_pkg::ALU_SHR;
            isa_pkg::OP_ASR:  ctl.exec.alu_op = isa_pkg::ALU_SAR;
            isa_pkg::OP_ASL:  ctl.exec.alu_op = isa_pkg::ALU_SAL;
            isa_pkg::OP_CSR:  ctl.exec.alu_op = isa_pkg::ALU_ROR;
            isa_pkg::OP_CSL:  ctl.exec.alu_op = isa_pkg::ALU_ROL;
            isa_pkg::OP_ADD,
            isa_pkg::OP_MULL: ctl.exec.alu_op = (opc == 7'd13) ? isa_pkg::ALU_ADD
                                                                : isa_pkg::ALU_MUL;
            isa_pkg::OP_SUB:  ctl.exec.alu_op = isa_pkg::ALU_SUB;
            isa_pkg::OP_MULH: begin
                ctl.exec.alu_op = isa_pkg::ALU_MUL;
                ctl.wb.op       = isa_pkg::WB_HIGH;  // upper half to c
            end
            isa_pkg::OP_MUL, isa_pkg::OP_MOV: begin
                ctl.exec.alu_op = (opc == 7'd17) ? isa_pkg::ALU_MUL : isa_pkg::ALU_NOP;
                ctl.wb.op       = isa_pkg::WB_TWO;   // c and d
                ctl.wb.a2       = fd;
                no_imm          = 1'b1;
            end
            isa_pkg::OP_INV, isa_pkg::OP_CSG, isa_pkg::OP_MOVS: begin
                ctl.exec.alu_op = (opc == 7'd5)  ? isa_pkg::ALU_NOT :
                                  (opc == 7'd18) ? isa_pkg::ALU_CPL : isa_pkg::ALU_NOP;
                rd_mask         = 2'b01;
                single          = 1'b1;
            end
            isa_pkg::OP_INC, isa_pkg::OP_DEC: begin
                ctl.exec.alu_op = (opc == 7'd19) ? isa_pkg::ALU_ADD : isa_pkg::ALU_SUB;
                rd_mask         = 2'b01;
                single          = 1'b1;
                one_b           = 1'b1;              // b forced to 1
            end
            isa_pkg::OP_CMP, isa_pkg::OP_CMN, isa_pkg::OP_TST: begin
                ctl.exec.alu_op = (opc == 7'd21) ? isa_pkg::ALU_SUB :
                                  (opc == 7'd22) ? isa_pkg::ALU_ADD : isa_pkg::ALU_AND;
                ctl.wb          = '0;                // flags only
            end
            isa_pkg::OP_BR, isa_pkg::OP_RET: begin
                ctl.wb.a1       = `PC_REG;
                rd_mask         = 2'b01;
                single          = 1'b1;
                no_imm          = (opc == 7'd27);
                rd_req.r1_addr  = (opc == 7'd27) ? `LR_REG : fa;
            end
            isa_pkg::OP_RBR: begin
                ctl.exec.alu_op = isa_pkg::ALU_ADD;  // pc + a
                ctl.wb.a1       = `PC_REG;
                rd_req.r1_addr  = `PC_REG;
                rd_req.r2_addr  = fa;
                single          = 1'b1;
            end
            isa_pkg::OP_BRL: begin
                ctl.wb.op       = isa_pkg::WB_TWO;   // pc and lr
                ctl.wb.a1       = `PC_REG;
                ctl.wb.a2       = `LR_REG;
                rd_req.r2_addr  = `PC_REG;           // old pc for link
                single          = 1'b1;
            end
            isa_pkg::OP_LDR, isa_pkg::OP_IN: begin
                ctl.mem.r1_op   = (opc == 7'd28) ? isa_pkg::MEM_READ : isa_pkg::MEM_SYS_RD;
                ctl.to_mem      = 1'b1;
                rd_mask         = 2'b01;
                single          = 1'b1;
            end
            isa_pkg::OP_STR, isa_pkg::OP_OUT: begin
                ctl.mem.r2_op   = (opc == 7'd29) ? isa_pkg::MEM_WRITE : isa_pkg::MEM_SYS_WR;
                ctl.wb          = '0;
                ctl.to_mem      = 1'b1;
                single          = 1'b1;
            end
            default: begin                           // nop and unknown
                ctl.exec     = '0;
                ctl.mem      = '0;
                ctl.wb       = '0;
                rd_req       = '0;
                rd_mask      = 2'b00;
                no_imm       = 1'b1;
            end
        endcase
        // flag mask for logic, shift and arithmetic ops
        ctl.exec.write_flags = (opc <= 7'd23 && opc != 7'd0) ? 4'hF : 4'h0;

        imm_sel = imm_raw;
        if (single)
            imm_sel[0] = 1'b0;                       // drop imm to b
        if (no_imm)
            imm_sel = isa_pkg::IMM_NONE;
        rd_req.read   = rd_mask & ~{imm_sel[0], imm_sel[1]};  // imm slot not read
        ctl.imm_count = {1'b0, imm_sel[0]} + {1'b0, imm_sel[1]};
        ctl.src_a = imm_sel[1]     ? isa_pkg::SRC_IMM :
                    rd_req.read[0] ? isa_pkg::SRC_REG : isa_pkg::SRC_ZERO;
        ctl.src_b = one_b          ? isa_pkg::SRC_ONE :
                    imm_sel[0]     ? isa_pkg::SRC_IMM :
                    rd_req.read[1] ? isa_pkg::SRC_REG : isa_pkg::SRC_ZERO;
    end

endmodule

// File: decode_pkg.sv
`include "insn_macros.svh"

package decode_pkg;

    typedef struct packed {
        isa_pkg::alu_op_e    alu_op;
        logic [`COND_W-1:0]  cond;
        logic [`COND_W-1:0]  write_flags;  // flag mask
        logic                is_cond;
    } exec_ctl_t;

    typedef struct packed {
        isa_pkg::mem_op_e r1_op;
        isa_pkg::mem_op_e r2_op;
    } mem_ctl_t;

    typedef struct packed {
        isa_pkg::wb_op_e         op;
        logic [`REG_ADDR_W-1:0]  a1;
        logic [`REG_ADDR_W-1:0]  a2;
    } reg_wb_t;

    typedef struct packed {
        logic [`REG_ADDR_W-1:0] r1_addr;
        logic [`REG_ADDR_W-1:0] r2_addr;
        logic [1:0]             read;  // bit0 r1, bit1 r2
    } reg_rd_t;

    typedef struct packed {
        exec_ctl_t       exec;
        mem_ctl_t        mem;
        reg_wb_t         wb;
        isa_pkg::src_e   src_a;
        isa_pkg::src_e   src_b;
        logic            to_mem;     // slot a feeds m_a1
        logic [1:0]      imm_count;  // words following insn
    } dec_ctl_t;

endpackage

// File: isa_pkg.sv
`include "insn_macros.svh"

package isa_pkg;

    typedef enum logic [`OPCODE_W-1:0] {
        OP_NOP  = 7'd0,  OP_OR   = 7'd1,  OP_NOR  = 7'd2,  OP_AND  = 7'd3,
        OP_NAND = 7'd4,  OP_INV  = 7'd5,  OP_XOR  = 7'd6,  OP_LSL  = 7'd7,
        OP_LSR  = 7'd8,  OP_ASR  = 7'd9,  OP_ASL  = 7'd10, OP_CSR  = 7'd11,
        OP_CSL  = 7'd12, OP_ADD  = 7'd13, OP_SUB  = 7'd14, OP_MULL = 7'd15,
        OP_MULH = 7'd16, OP_MUL  = 7'd17, OP_CSG  = 7'd18, OP_INC  = 7'd19,
        OP_DEC  = 7'd20, OP_CMP  = 7'd21, OP_CMN  = 7'd22, OP_TST  = 7'd23,
        OP_BR   = 7'd24, OP_RBR  = 7'd25, OP_BRL  = 7'd26, OP_RET  = 7'd27,
        OP_LDR  = 7'd28, OP_STR  = 7'd29, OP_IN   = 7'd30, OP_OUT  = 7'd31,
        OP_MOVS = 7'd32, OP_MOV  = 7'd33
    } opcode_e;

    typedef enum logic [`ALU_OP_W-1:0] {
        ALU_NOP = 8'h00, ALU_ADD = 8'h01, ALU_SUB = 8'h02, ALU_CPL = 8'h03,
        ALU_MUL = 8'h04, ALU_SHR = 8'h05, ALU_SHL = 8'h06, ALU_SAR = 8'h07,
        ALU_SAL = 8'h08, ALU_ROR = 8'h09, ALU_ROL = 8'h0A, ALU_NOT = 8'h0B,
        ALU_AND = 8'h0C, ALU_OR  = 8'h0D, ALU_XOR = 8'h0E, ALU_NAND = 8'h0F,
        ALU_NOR = 8'h10
    } alu_op_e;

    typedef enum logic [`MEM_OP_W-1:0] {
        MEM_NOP   = 4'h0,   // clean nop
        MEM_PASS  = 4'h1,   // passthrough
        MEM_READ  = 4'h2,
        MEM_WRITE = 4'h5,
        MEM_SYS_RD = 4'h8,  // in
        MEM_SYS_WR = 4'hB   // out
    } mem_op_e;

    typedef enum logic [3:0] {
        WB_NONE = 4'h0, WB_ONE = 4'h1, WB_HIGH = 4'h4, WB_TWO = 4'h8
    } wb_op_e;

    typedef enum logic [1:0] {
        IMM_NONE = 2'd0, IMM_B = 2'd1, IMM_A = 2'd2, IMM_AB = 2'd3
    } imm_sel_e;

    typedef enum logic [1:0] {
        SRC_ZERO = 2'd0, SRC_REG = 2'd1, SRC_IMM = 2'd2, SRC_ONE = 2'd3
    } src_e;

endpackage

// File: insn_macros.svh
`ifndef INSN_MACROS_SVH
`define INSN_MACROS_SVH

`define WORD_W      32  // data word
`define REG_ADDR_W  5   // 32 registers
`define OPCODE_W    7
`define COND_W      4   // cond code and flag mask
`define ALU_OP_W    8
`define MEM_OP_W    4

`define PC_REG      5'd31   // program counter
`define LR_REG      5'd29   // link register

// instruction word fields
`define F_OPCODE    31:25
`define F_COND      24:21
`define F_A         20:16
`define F_B         15:11
`define F_C         10:6
`define F_D         5:1
`define F_IMM_SEL   5:4     // overlaps d on purpose

`endif
